// ==== source/rv_defines.svh ====
`ifndef RV_DEFINES_SVH
`define RV_DEFINES_SVH

// datapath widths
`define INST_W          32
`define XLEN            64
`define PC_W            64

// register and opcode fields
`define OPCODE_FIELD    6:0
`define RD_FIELD        11:7
`define FUNCT3_FIELD    14:12
`define RS1_FIELD       19:15
`define RS2_FIELD       24:20

// immediate pieces
`define INST_31         31
`define INST_30_25      30:25
`define INST_30_21      30:21
`define INST_31_25      31:25
`define INST_31_20      31:20
`define INST_31_12      31:12
`define INST_25_20      25:20
`define INST_20         20
`define INST_19_15      19:15
`define INST_19_12      19:12
`define INST_11_8       11:8
`define INST_11_7       11:7
`define INST_7          7

`endif

// ==== source/rv_decode_pkg.sv ====
`include "rv_defines.svh"

package rv_decode_pkg;

    // RV64I major opcodes
    typedef enum logic [6:0] {
        opc_load     = 7'b0000011,
        opc_op_imm   = 7'b0010011,
        opc_auipc    = 7'b0010111,
        opc_op_imm32 = 7'b0011011,
        opc_store    = 7'b0100011,
        opc_op       = 7'b0110011,
        opc_lui      = 7'b0110111,
        opc_op32     = 7'b0111011,
        opc_branch   = 7'b1100011,
        opc_jalr     = 7'b1100111,
        opc_jal      = 7'b1101111,
        opc_system   = 7'b1110011
    } opcode_e;

    typedef enum logic [2:0] {
        imm_none     = 3'd0,
        imm_csr_zimm = 3'd1,
        imm_shift    = 3'd2,
        imm_store    = 3'd3,
        imm_upper    = 3'd4,
        imm_jump     = 3'd5,
        imm_itype    = 3'd6,
        imm_branch   = 3'd7
    } imm_type_e;

    typedef enum logic [3:0] {
        cls_alu_reg,
        cls_alu_imm,
        cls_load,
        cls_store,
        cls_branch,
        cls_jal,
        cls_jalr,
        cls_upper,
        cls_csr,
        cls_system,
        cls_illegal
    } inst_class_e;

    typedef struct packed {
        logic [`PC_W-1:0]   pc;
        logic [`INST_W-1:0] inst;
    } fetch_packet_t;

    typedef struct packed {
        logic [`PC_W-1:0] pc;
        inst_class_e      inst_class;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [4:0]       rs2;
        logic [2:0]       funct3;
        logic             word_op;  // op_imm32 / op32
        logic [`XLEN-1:0] imm;
    } decoded_inst_t;

endpackage

// ==== source/inst_receiver.sv ====
`timescale 1ns/1ns

module inst_receiver (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         in_req,
    input  rv_decode_pkg::fetch_packet_t in_data,
    output logic                         in_ack,
    input  logic                         fetch_ready,
    output logic                         fetch_valid,
    output rv_decode_pkg::fetch_packet_t fetch_packet
);
    import rv_decode_pkg::*;

    typedef enum logic [1:0] {
        idle,
        ack_high,
        wait_release
    } rx_state_e;

    rx_state_e     state;
    fetch_packet_t buffer;
    logic          full;
    logic          capture;
    logic          drain;

    // take a packet only with ack low and room in the buffer
    assign capture = (state == idle) && in_req && !full;
    assign drain   = full && fetch_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (capture) begin
                        state <= ack_high;
                    end
                end
                ack_high: begin
                    state <= in_req ? wait_release : idle;
                end
                wait_release: begin
                    if (!in_req) begin
                        state <= idle;  // ack drops on the first low req
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            full <= 1'b0;
        end else if (capture) begin
            full <= 1'b1;
        end else if (drain) begin
            full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            buffer <= in_data;
        end
    end

    assign in_ack       = (state != idle);
    assign fetch_valid  = full;
    assign fetch_packet = buffer;

endmodule

// ==== source/inst_decoder.sv ====
`timescale 1ns/1ns

`include "rv_defines.svh"

module inst_decoder (
    input  logic [`INST_W-1:0]        inst,
    output rv_decode_pkg::inst_class_e inst_class,
    output rv_decode_pkg::imm_type_e   imm_type,
    output logic [4:0]                 rd,
    output logic [4:0]                 rs1,
    output logic [4:0]                 rs2,
    output logic [2:0]                 funct3,
    output logic                       word_op
);
    import rv_decode_pkg::*;

    logic is_shift;

    // register fields are taken as-is, unused ones are ignored downstream
    assign rd     = inst[`RD_FIELD];
    assign rs1    = inst[`RS1_FIELD];
    assign rs2    = inst[`RS2_FIELD];
    assign funct3 = inst[`FUNCT3_FIELD];

    // slli / srli / srai and their word forms
    assign is_shift = (inst[`FUNCT3_FIELD] == 3'b001) || (inst[`FUNCT3_FIELD] == 3'b101);

    always_comb begin
        inst_class = cls_illegal;
        imm_type   = imm_none;
        word_op    = 1'b0;
        case (inst[`OPCODE_FIELD])
            opc_load: begin
                inst_class = cls_load;
                imm_type   = imm_itype;
            end
            opc_op_imm: begin
                inst_class = cls_alu_imm;
                imm_type   = is_shift ? imm_shift : imm_itype;
            end
            opc_op_imm32: begin
                inst_class = cls_alu_imm;
                imm_type   = is_shift ? imm_shift : imm_itype;
                word_op    = 1'b1;
            end
            opc_auipc, opc_lui: begin
                inst_class = cls_upper;
                imm_type   = imm_upper;
            end
            opc_store: begin
                inst_class = cls_store;
                imm_type   = imm_store;
            end
            opc_op: begin
                inst_class = cls_alu_reg;
            end
            opc_op32: begin
                inst_class = cls_alu_reg;
                word_op    = 1'b1;
            end
            opc_branch: begin
                inst_class = cls_branch;
                imm_type   = imm_branch;
            end
            opc_jalr: begin
                inst_class = cls_jalr;
                imm_type   = imm_itype;
            end
            opc_jal: begin
                inst_class = cls_jal;
                imm_type   = imm_jump;
            end
            opc_system: begin
                // funct3 000 is ecall/ebreak/xret, the rest are csr ops
                if (inst[`FUNCT3_FIELD] == 3'b000) begin
                    inst_class = cls_system;
                end else begin
                    inst_class = cls_csr;
                    if (inst[14]) begin
                        imm_type = imm_csr_zimm;  // csrrwi and friends
                    end
                end
            end
            default: begin
                inst_class = cls_illegal;
            end
        endcase
    end

endmodule

// ==== source/imm_generator.sv ====
`timescale 1ns/1ns

`include "rv_defines.svh"

module imm_generator (
    input  rv_decode_pkg::imm_type_e imm_type,
    input  logic [`INST_W-1:0]       inst,
    output logic [`XLEN-1:0]         imm
);
    import rv_decode_pkg::*;

    logic [`INST_W-1:0] imm_st;
    logic [`INST_W-1:0] imm_up;
    logic [`INST_W-1:0] imm_j;
    logic [`INST_W-1:0] imm_i;
    logic [`INST_W-1:0] imm_b;
    logic [`INST_W-1:0] imm_sh;
    logic [`INST_W-1:0] imm_z;
    logic [`INST_W-1:0] imm_pre;

    assign imm_st = {{20{inst[`INST_31]}}, inst[`INST_31_25], inst[`INST_11_7]};

    assign imm_up = {inst[`INST_31_12], 12'b0};

    assign imm_j  = {{12{inst[`INST_31]}}, inst[`INST_19_12], inst[`INST_20],
                     inst[`INST_30_21], 1'b0};

    assign imm_i  = {{20{inst[`INST_31]}}, inst[`INST_31_20]};

    // offset bit 12 sits in inst bit 31, bit 11 in inst bit 7
    assign imm_b  = {{20{inst[`INST_31]}}, inst[`INST_7], inst[`INST_30_25],
                     inst[`INST_11_8], 1'b0};

    assign imm_sh = {26'b0, inst[`INST_25_20]};  // shamt, 6 bits on rv64
    assign imm_z  = {27'b0, inst[`INST_19_15]};

    always_comb begin
        case (imm_type)
            imm_store:    imm_pre = imm_st;
            imm_upper:    imm_pre = imm_up;
            imm_jump:     imm_pre = imm_j;
            imm_itype:    imm_pre = imm_i;
            imm_branch:   imm_pre = imm_b;
            imm_shift:    imm_pre = imm_sh;
            imm_csr_zimm: imm_pre = imm_z;
            default:      imm_pre = '0;
        endcase
    end

    // shift and zimm have bit 31 clear, so they stay zero-extended
    assign imm = {{(`XLEN - `INST_W){imm_pre[`INST_W-1]}}, imm_pre};

endmodule

// ==== source/decode_core.sv ====
`timescale 1ns/1ns

module decode_core (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         fetch_valid,
    input  rv_decode_pkg::fetch_packet_t fetch_packet,
    output logic                         fetch_ready,
    output logic                         dec_valid,
    input  logic                         dec_ready,
    output rv_decode_pkg::decoded_inst_t dec_packet
);
    import rv_decode_pkg::*;

    inst_class_e   inst_class;
    imm_type_e     imm_type;
    logic [4:0]    rd;
    logic [4:0]    rs1;
    logic [4:0]    rs2;
    logic [2:0]    funct3;
    logic          word_op;
    logic [63:0]   imm;
    decoded_inst_t decoded;
    decoded_inst_t stage;
    logic          stage_valid;
    logic          load;
    logic          unload;

    inst_decoder inst_decoder_inst (
        .inst       (fetch_packet.inst),
        .inst_class (inst_class),
        .imm_type   (imm_type),
        .rd         (rd),
        .rs1        (rs1),
        .rs2        (rs2),
        .funct3     (funct3),
        .word_op    (word_op)
    );

    imm_generator imm_generator_inst (
        .imm_type (imm_type),
        .inst     (fetch_packet.inst),
        .imm      (imm)
    );

    always_comb begin
        decoded.pc         = fetch_packet.pc;
        decoded.inst_class = inst_class;
        decoded.rd         = rd;
        decoded.rs1        = rs1;
        decoded.rs2        = rs2;
        decoded.funct3     = funct3;
        decoded.word_op    = word_op;
        decoded.imm        = imm;
    end

    assign unload      = stage_valid && dec_ready;
    assign fetch_ready = !stage_valid || dec_ready;  // empty or emptied this edge
    assign load        = fetch_valid && fetch_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            stage_valid <= 1'b0;
        end else if (load) begin
            stage_valid <= 1'b1;
        end else if (unload) begin
            stage_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            stage <= decoded;
        end
    end

    assign dec_valid  = stage_valid;
    assign dec_packet = stage;

endmodule

// ==== source/decode_sender.sv ====
`timescale 1ns/1ns

module decode_sender (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         dec_valid,
    input  rv_decode_pkg::decoded_inst_t dec_packet,
    output logic                         dec_ready,
    output logic                         out_req,
    input  logic                         out_ack,
    output rv_decode_pkg::decoded_inst_t out_data
);
    import rv_decode_pkg::*;

    typedef enum logic [1:0] {
        idle,
        req_high,
        wait_release
    } tx_state_e;

    tx_state_e     state;
    decoded_inst_t hold;
    logic          accept;

    // previous exchange must be fully closed before the next one
    assign dec_ready = (state == idle) && !out_ack;
    assign accept    = dec_valid && dec_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (accept) begin
                        state <= req_high;
                    end
                end
                req_high: begin
                    if (out_ack) begin
                        state <= wait_release;  // req drops here
                    end
                end
                wait_release: begin
                    if (!out_ack) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // payload held for the whole exchange
    always_ff @(posedge clk) begin
        if (accept) begin
            hold <= dec_packet;
        end
    end

    assign out_req  = (state == req_high);
    assign out_data = hold;

endmodule

// ==== source/decode_top.sv ====
`timescale 1ns/1ns

module decode_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         in_req,
    input  rv_decode_pkg::fetch_packet_t in_data,
    output logic                         in_ack,
    output logic                         out_req,
    input  logic                         out_ack,
    output rv_decode_pkg::decoded_inst_t out_data
);
    import rv_decode_pkg::*;

    logic          fetch_valid;
    logic          fetch_ready;
    fetch_packet_t fetch_packet;
    logic          dec_valid;
    logic          dec_ready;
    decoded_inst_t dec_packet;

    inst_receiver inst_receiver_inst (
        .clk          (clk),
        .reset        (reset),
        .in_req       (in_req),
        .in_data      (in_data),
        .in_ack       (in_ack),
        .fetch_ready  (fetch_ready),
        .fetch_valid  (fetch_valid),
        .fetch_packet (fetch_packet)
    );

    decode_core decode_core_inst (
        .clk          (clk),
        .reset        (reset),
        .fetch_valid  (fetch_valid),
        .fetch_packet (fetch_packet),
        .fetch_ready  (fetch_ready),
        .dec_valid    (dec_valid),
        .dec_ready    (dec_ready),
        .dec_packet   (dec_packet)
    );

    decode_sender decode_sender_inst (
        .clk        (clk),
        .reset      (reset),
        .dec_valid  (dec_valid),
        .dec_packet (dec_packet),
        .dec_ready  (dec_ready),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_data   (out_data)
    );

endmodule

// ==== verif/decode_tb.sv ====
`timescale 1ns/1ns

`include "rv_defines.svh"

module decode_tb;
    import rv_decode_pkg::*;

    localparam int TIMEOUT = 200;  // cycles per wait

    logic          clk;
    logic          reset;
    logic          in_req;
    fetch_packet_t in_data;
    logic          in_ack;
    logic          out_req;
    logic          out_ack;
    decoded_inst_t out_data;

    // stimulus table, one column per queue
    logic [`INST_W-1:0] inst_q[$];
    logic [`PC_W-1:0]   pc_q[$];
    inst_class_e        cls_q[$];
    logic [`XLEN-1:0]   imm_q[$];
    int                 delay_q[$];

    int            accepted;
    int            done;
    int            max_in_flight;
    logic          prev_in_req;
    logic          prev_in_ack;
    logic          prev_out_req;
    logic          prev_out_ack;
    decoded_inst_t prev_out_data;

    decode_top decode_top_inst (
        .clk      (clk),
        .reset    (reset),
        .in_req   (in_req),
        .in_data  (in_data),
        .in_ack   (in_ack),
        .out_req  (out_req),
        .out_ack  (out_ack),
        .out_data (out_data)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("*** TEST FAILED ***");
        $fatal(1, "stopping at first error");
    endtask

    task automatic check_field(input string name, input logic [63:0] exp,
                               input logic [63:0] act, input int idx);
        assert (exp === act) else report_failure($sformatf(
            "mismatch %s expected %h actual %h (entry %0d)", name, exp, act, idx));
    endtask

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // expected immediate straight from the format rules
    function automatic logic [63:0] ref_imm(input logic [31:0] w);
        logic signed [31:0] s;
        logic [31:0]        v;
        s = $signed(w);
        v = 32'h0;
        case (w[6:0])
            7'b0000011, 7'b1100111: v = s >>> 20;
            7'b0010011, 7'b0011011: begin
                if (w[13:12] == 2'b01) begin
                    v = {26'h0, w[25:20]};  // funct3 001 or 101
                end else begin
                    v = s >>> 20;
                end
            end
            7'b0100011: begin
                v = s >>> 25;
                v = (v << 5) | {27'h0, w[11:7]};
            end
            7'b1100011: begin
                v = s >>> 31;
                v = (v << 12) | {20'h0, w[7], w[30:25], w[11:8], 1'b0};
            end
            7'b1101111: begin
                v = s >>> 31;
                v = (v << 20) | {12'h0, w[19:12], w[20], w[30:21], 1'b0};
            end
            7'b0110111, 7'b0010111: v = w & 32'hFFFFF000;
            7'b1110011: v = w[14] ? {27'h0, w[19:15]} : 32'h0;
            default: v = 32'h0;
        endcase
        return {{32{v[31]}}, v};
    endfunction

    task automatic add_entry(input logic [31:0] inst, input logic [63:0] pc,
                             input inst_class_e cls, input logic [63:0] imm, input int delay);
        inst_q.push_back(inst);
        pc_q.push_back(pc);
        cls_q.push_back(cls);
        imm_q.push_back(imm);
        delay_q.push_back(delay);
    endtask

    task automatic build_table();
        logic [6:0]  opcs [8] = '{7'h03, 7'h23, 7'h63, 7'h6F, 7'h37, 7'h13, 7'h1B, 7'h67};
        inst_class_e classes [8] = '{cls_load, cls_store, cls_branch, cls_jal,
                                     cls_upper, cls_alu_imm, cls_alu_imm, cls_jalr};
        logic [31:0] rng;
        logic [31:0] w;
        rng = 32'h7e5;
        add_entry(32'hFFF00093, 64'h8000_0000, cls_alu_imm, 64'hFFFF_FFFF_FFFF_FFFF, 0);
        add_entry(32'h00812283, 64'h8000_0004, cls_load, 64'h8, 1);
        add_entry(32'hFE313823, 64'h8000_0008, cls_store, 64'hFFFF_FFFF_FFFF_FFF0, 0);
        add_entry(32'hFE208CE3, 64'h8000_000C, cls_branch, 64'hFFFF_FFFF_FFFF_FFF8, 12);
        add_entry(32'h00419863, 64'h8000_0010, cls_branch, 64'h10, 0);
        add_entry(32'hFFDFF0EF, 64'h8000_0014, cls_jal, 64'hFFFF_FFFF_FFFF_FFFC, 2);
        add_entry(32'h00008067, 64'h8000_0018, cls_jalr, 64'h0, 0);
        add_entry(32'h800002B7, 64'h8000_001C, cls_upper, 64'hFFFF_FFFF_8000_0000, 0);
        add_entry(32'h12345197, 64'hFFFF_FFFF_FFFF_FFFC, cls_upper, 64'h1234_5000, 1);
        add_entry(32'h02109093, 64'h8000_0024, cls_alu_imm, 64'h21, 15);  // slli 33
        add_entry(32'h43F15113, 64'h8000_0028, cls_alu_imm, 64'h3F, 0);   // srai 63
        add_entry(32'hFFB2021B, 64'h8000_002C, cls_alu_imm, 64'hFFFF_FFFF_FFFF_FFFB, 0);
        add_entry(32'h002081B3, 64'h8000_0030, cls_alu_reg, 64'h0, 3);
        add_entry(32'h407302BB, 64'h8000_0034, cls_alu_reg, 64'h0, 0);    // subw
        add_entry(32'h3002D0F3, 64'h8000_0038, cls_csr, 64'h5, 1);        // csrrwi
        add_entry(32'hFFFFA173, 64'h8000_003C, cls_csr, 64'h0, 0);
        add_entry(32'h00000073, 64'h8000_0040, cls_system, 64'h0, 0);
        add_entry(32'hFFFFFFFF, 64'h8000_0044, cls_illegal, 64'h0, 2);
        add_entry(32'h0000000B, 64'h8000_0048, cls_illegal, 64'h0, 0);
        for (int i = 0; i < 8; i++) begin
            rng = next_random(rng);
            w = {rng[31:7], opcs[i]};
            rng = next_random(rng);
            add_entry(w, {32'h0, rng[31:2], 2'b00}, classes[i], ref_imm(w), int'(rng[1:0]));
        end
    endtask

    task automatic send_entry(input int idx);
        int cycles;
        in_data.pc   = pc_q[idx];
        in_data.inst = inst_q[idx];
        in_req       = 1'b1;
        cycles = 0;
        while (!in_ack) begin
            @(posedge clk);
            #10;
            cycles++;
            assert (cycles <= TIMEOUT) else report_failure($sformatf(
                "input exchange stalled waiting for in_ack to rise (entry %0d)", idx));
        end
        accepted++;
        if (accepted - done > max_in_flight) begin
            max_in_flight = accepted - done;
        end
        in_req = 1'b0;
        cycles = 0;
        while (in_ack) begin
            @(posedge clk);
            #10;
            cycles++;
            assert (cycles <= TIMEOUT) else report_failure($sformatf(
                "input exchange stalled waiting for in_ack to fall (entry %0d)", idx));
        end
    endtask

    task automatic receive_entry(input int idx);
        int          cycles;
        logic [31:0] w;
        logic        word;
        w = inst_q[idx];
        word = (w[6:0] == 7'b0011011) || (w[6:0] == 7'b0111011);
        cycles = 0;
        while (!out_req) begin
            @(posedge clk);
            #10;
            cycles++;
            assert (cycles <= TIMEOUT) else report_failure($sformatf(
                "output exchange stalled waiting for out_req to rise (entry %0d)", idx));
        end
        check_field("out_data.pc", pc_q[idx], out_data.pc, idx);
        check_field("out_data.inst_class", 64'(cls_q[idx]), 64'(out_data.inst_class), idx);
        check_field("out_data.imm", imm_q[idx], out_data.imm, idx);
        check_field("out_data.rd", 64'(w[11:7]), 64'(out_data.rd), idx);
        check_field("out_data.rs1", 64'(w[19:15]), 64'(out_data.rs1), idx);
        check_field("out_data.rs2", 64'(w[24:20]), 64'(out_data.rs2), idx);
        check_field("out_data.funct3", 64'(w[14:12]), 64'(out_data.funct3), idx);
        check_field("out_data.word_op", 64'(word), 64'(out_data.word_op), idx);
        repeat (delay_q[idx]) begin
            @(posedge clk);
            #10;
        end
        out_ack = 1'b1;
        cycles = 0;
        while (out_req) begin
            @(posedge clk);
            #10;
            cycles++;
            assert (cycles <= TIMEOUT) else report_failure($sformatf(
                "output exchange stalled waiting for out_req to fall (entry %0d)", idx));
        end
        out_ack = 1'b0;
        done++;
    endtask

    // four-phase order at both ports, payload held while out_req is high
    always @(negedge clk) begin
        if (!reset) begin
            if (in_ack && !prev_in_ack) begin
                assert (prev_in_req) else report_failure("in_ack rose with no in_req pending");
            end
            if (!in_ack && prev_in_ack) begin
                assert (!prev_in_req) else report_failure("in_ack fell while in_req was high");
            end
            if (out_req && !prev_out_req) begin
                assert (!prev_out_ack) else report_failure("out_req rose before out_ack fell");
            end
            if (!out_req && prev_out_req) begin
                assert (prev_out_ack) else report_failure("out_req fell without out_ack");
            end
            if (out_req && prev_out_req) begin
                assert (out_data === prev_out_data) else report_failure($sformatf(
                    "mismatch out_data expected %h actual %h", prev_out_data, out_data));
            end
        end
        prev_in_req   = in_req;
        prev_in_ack   = in_ack;
        prev_out_req  = out_req;
        prev_out_ack  = out_ack;
        prev_out_data = out_data;
    end

    initial begin
        in_req        = 1'b0;
        in_data       = '0;
        out_ack       = 1'b0;
        reset         = 1'b1;
        accepted      = 0;
        done          = 0;
        max_in_flight = 0;
        build_table();
        repeat (3) @(posedge clk);
        #10;
        reset = 1'b0;
        repeat (4) begin
            @(posedge clk);
            #10;
            assert (!in_ack && !out_req) else report_failure(
                "in_ack or out_req went high before any request");
        end
        fork
            begin
                for (int i = 0; i < inst_q.size(); i++) begin
                    send_entry(i);
                end
            end
            begin
                for (int k = 0; k < inst_q.size(); k++) begin
                    receive_entry(k);
                end
            end
        join
        assert (max_in_flight >= 3) begin
            $display("*** TEST PASSED ***");
            $finish;
        end else begin
            report_failure("slow out_ack never left three instructions in flight");
        end
    end

endmodule

// ==== src.f ====
+incdir+source
source/rv_decode_pkg.sv
source/inst_receiver.sv
source/inst_decoder.sv
source/imm_generator.sv
source/decode_core.sv
source/decode_sender.sv
source/decode_top.sv
verif/decode_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns -j 0
TOP       = decode_tb
FILELIST  = src.f
PASS_MSG  = *** TEST PASSED ***

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf obj_dir
